//--- sources.f
src/lc3b_isa_pkg.sv
src/lc3b_ctrl_pkg.sv
src/regfile.sv
src/forwarding_unit.sv
src/hazard_detection.sv
src/cpu_control.sv
src/cpu_datapath.sv
src/cpu.sv
tests/clock_gen.sv
tests/cpu_properties.sv
tests/cpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -f sources.f \
    --Mdir obj_dir -o cpu_tb_sim

./obj_dir/cpu_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
exit 1

//--- tests/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;

localparam lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000;
localparam int NUM_INSTR      = 64;
localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 200;

logic clk;
logic arst_n;
logic imem_resp = 1'b0;
logic dmem_resp = 1'b0;
lc3b_isa_pkg::lc3b_word imem_rdata = '0;
lc3b_isa_pkg::lc3b_word dmem_rdata = '0;
lc3b_isa_pkg::lc3b_word imem_addr, dmem_addr, dmem_wdata;
logic imem_read, dmem_read, dmem_write;

logic [31:0] lfsr_state = 32'h045bdea9;
lc3b_isa_pkg::lc3b_word prog [NUM_INSTR];
lc3b_isa_pkg::lc3b_word ref_mem [lc3b_isa_pkg::lc3b_word];
lc3b_isa_pkg::lc3b_word dev_mem [lc3b_isa_pkg::lc3b_word];
// expected data accesses in program order
logic exp_write [$];
lc3b_isa_pkg::lc3b_word exp_addr [$];
lc3b_isa_pkg::lc3b_word exp_data [$];
int acc_idx = 0;
int check_errors = 0;
int other_errors = 0;
int imem_wait = 0;
int dmem_wait = 0;
logic pc_checked = 1'b0;
lc3b_isa_pkg::lc3b_reg last1 = 3'd0;
lc3b_isa_pkg::lc3b_reg last2 = 3'd1;

clock_gen #(.PERIOD(10), .RESET_CYCLES(3)) u_clock_gen (.o_clk(clk), .o_arst_n(arst_n));

cpu dut_i (
    .clk          (clk),
    .i_arst_n     (arst_n),
    .i_imem_resp  (imem_resp),
    .i_imem_rdata (imem_rdata),
    .o_imem_addr  (imem_addr),
    .o_imem_read  (imem_read),
    .i_dmem_resp  (dmem_resp),
    .i_dmem_rdata (dmem_rdata),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_read  (dmem_read),
    .o_dmem_write (dmem_write)
);

// galois lfsr stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return v;
endfunction

// initial data memory contents
function automatic lc3b_isa_pkg::lc3b_word mem_fill(input lc3b_isa_pkg::lc3b_word a);
    lc3b_isa_pkg::lc3b_word p;
    p = a * 16'h9e37;
    return p ^ 16'h5a5a;
endfunction

function automatic lc3b_isa_pkg::lc3b_word read_word(input logic dev,
                                                     input lc3b_isa_pkg::lc3b_word a);
    if (dev) begin
        return dev_mem.exists(a) ? dev_mem[a] : mem_fill(a);
    end
    return ref_mem.exists(a) ? ref_mem[a] : mem_fill(a);
endfunction

task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        check_errors++;
    end
endtask

task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    other_errors++;
endtask

// mostly recent destinations so EX needs forwarded values
function automatic lc3b_isa_pkg::lc3b_reg pick_reg(input logic allow_r7);
    logic [31:0] r;
    r = rand_bits(2);
    if (r == 0) return last1;
    if (r == 1) return last2;
    r = rand_bits(3);
    if (r == 7 && !allow_r7) return 3'(rand_bits(2));
    return 3'(r);
endfunction

task automatic build_program();
    lc3b_isa_pkg::lc3b_reg dr, s1, s2;
    logic [2:0] kind;
    logic [5:0] off6;
    logic [8:0] off9;
    for (int i = 0; i < 54; i++) begin
        kind = 3'(rand_bits(3));
        dr   = pick_reg(1'b0);
        s1   = pick_reg(1'b1);
        s2   = pick_reg(1'b1);
        off6 = 6'(rand_bits(6));
        case (kind)
            3'd0: prog[i] = {4'b0001, dr, s1, 3'b000, s2};
            3'd1: prog[i] = {4'b0001, dr, s1, 1'b1, off6[4:0]};
            3'd2: prog[i] = {4'b0101, dr, s1, 3'b000, s2};
            3'd3: prog[i] = {4'b0101, dr, s1, 1'b1, off6[4:0]};
            3'd4: prog[i] = {4'b1001, dr, s1, 6'b111111};
            3'd5: prog[i] = {4'b0110, dr, 3'd7, off6};
            3'd6: prog[i] = {4'b0111, s2, 3'd7, off6};
            default: begin
                // forward only and never past the dump
                off9 = 9'(rand_bits(3));
                if (i + 1 + int'(off9) > 54) off9 = 9'(53 - i);
                prog[i] = {4'b0000, 3'(rand_bits(3)), off9};
            end
        endcase
        if (kind <= 3'd5) begin
            last2 = last1;
            last1 = dr;
        end
    end
    for (int i = 0; i < 7; i++) begin
        prog[54 + i] = {4'b0111, 3'(i), 3'd7, 6'(i)};
    end
    // condition code shows up in the last stored word
    prog[61] = {4'b0000, 3'b010, 9'd1};
    prog[62] = {4'b1001, 3'd6, 3'd6, 6'b111111};
    prog[63] = {4'b0111, 3'd6, 3'd7, 6'd7};
endtask

task automatic run_model();
    lc3b_isa_pkg::lc3b_word r [8];
    lc3b_isa_pkg::lc3b_word pc, w, b, res, addr;
    logic [2:0] cc;
    logic wr;
    for (int i = 0; i < 8; i++) begin
        r[i] = '0;
    end
    pc = RESET_PC;
    cc = 3'b010;
    while (pc < 16'(NUM_INSTR * 2)) begin
        w    = prog[pc[6:1]];
        pc   = pc + 16'd2;
        wr   = 1'b1;
        b    = w[5] ? {{11{w[4]}}, w[4:0]} : r[w[2:0]];
        addr = r[w[8:6]] + {{9{w[5]}}, w[5:0], 1'b0};
        res  = '0;
        case (w[15:12])
            4'b0001: res = r[w[8:6]] + b;
            4'b0101: res = r[w[8:6]] & b;
            4'b1001: res = ~r[w[8:6]];
            4'b0110: begin
                res = read_word(1'b0, addr);
                exp_write.push_back(1'b0);
                exp_addr.push_back(addr);
                exp_data.push_back(res);
            end
            4'b0111: begin
                wr = 1'b0;
                ref_mem[addr] = r[w[11:9]];
                exp_write.push_back(1'b1);
                exp_addr.push_back(addr);
                exp_data.push_back(r[w[11:9]]);
            end
            default: begin
                wr = 1'b0;
                if (|(cc & w[11:9])) pc = pc + {{6{w[8]}}, w[8:0], 1'b0};
            end
        endcase
        if (wr) begin
            r[w[11:9]] = res;
            cc = {res[15], res == '0, !res[15] && res != '0};
        end
    end
endtask

// compare one data access with the next expected one and serve it
task automatic serve_access();
    lc3b_isa_pkg::lc3b_word data;
    data = dmem_write ? dmem_wdata : read_word(1'b1, dmem_addr);
    if (acc_idx >= exp_addr.size()) begin
        report_error($sformatf("unexpected data access at address %h", dmem_addr));
    end else begin
        check_equal($sformatf("access %0d kind", acc_idx), exp_write[acc_idx], dmem_write);
        check_equal($sformatf("access %0d address", acc_idx), exp_addr[acc_idx], dmem_addr);
        check_equal($sformatf("access %0d data", acc_idx), exp_data[acc_idx], data);
    end
    acc_idx++;
    if (dmem_write) begin
        dev_mem[dmem_addr] = dmem_wdata;
    end else begin
        dmem_rdata <= data;
    end
endtask

// instruction and data memory models with random response delays
always @(posedge clk) begin
    if (!arst_n) begin
        if (dmem_read || dmem_write) report_error("data access during reset");
    end else begin
        if (!imem_read) begin
            report_error("instruction fetch request is low after reset");
        end
        if (!pc_checked) begin
            check_equal("reset fetch address", RESET_PC, imem_addr);
            pc_checked = 1'b1;
        end
        if (imem_resp) begin
            imem_resp <= 1'b0;
            imem_wait = int'(rand_bits(2));
        end else if (imem_wait == 0) begin
            imem_resp  <= 1'b1;
            imem_rdata <= (imem_addr < 16'(NUM_INSTR * 2)) ? prog[imem_addr[6:1]] : '0;
        end else begin
            imem_wait--;
        end
        if (dmem_resp) begin
            dmem_resp <= 1'b0;
            dmem_wait = int'(rand_bits(2));
        end else if (dmem_read || dmem_write) begin
            if (dmem_wait == 0) begin
                dmem_resp <= 1'b1;
                serve_access();
            end else begin
                dmem_wait--;
            end
        end
    end
end

initial begin
    build_program();
    run_model();
    @(posedge arst_n);
    while (acc_idx < exp_addr.size()) @(posedge clk);
    // idle tail catches extra accesses
    repeat (40) @(posedge clk);
    check_equal("access count", exp_addr.size(), acc_idx);
    $display("errors: %0d value mismatches, %0d other", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
end

initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    report_error($sformatf("timeout after %0d cycles with %0d of %0d data accesses seen",
                           TIMEOUT_CYCLES, acc_idx, exp_addr.size()));
    $display("errors: %0d value mismatches, %0d other", check_errors, other_errors);
    $display("Testbench failed");
    $finish;
end

endmodule : cpu_tb

//--- tests/cpu_properties.sv
`timescale 1ns/1ns

module cpu_properties (
    input logic                   clk,
    input logic                   i_arst_n,
    input logic                   i_imem_resp,
    input logic                   o_imem_read,
    input lc3b_isa_pkg::lc3b_word o_imem_addr,
    input logic                   i_dmem_resp,
    input logic                   o_dmem_read,
    input logic                   o_dmem_write,
    input lc3b_isa_pkg::lc3b_word o_dmem_addr,
    input lc3b_isa_pkg::lc3b_word o_dmem_wdata
);

// one data access at a time
dmem_exclusive: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(o_dmem_read && o_dmem_write))
    else $error("dmem read and write are high together");

// fetch address held while the fetch waits
imem_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_imem_read && !i_imem_resp) |=> (o_imem_read && o_imem_addr == $past(o_imem_addr)))
    else $error("imem request changed before its response");

// data request, address and store data held until resp
dmem_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    ((o_dmem_read || o_dmem_write) && !i_dmem_resp) |=>
        (o_dmem_read == $past(o_dmem_read) && o_dmem_write == $past(o_dmem_write)
         && o_dmem_addr == $past(o_dmem_addr)
         && (!o_dmem_write || o_dmem_wdata == $past(o_dmem_wdata))))
    else $error("dmem request changed before its response");

endmodule : cpu_properties

bind cpu cpu_properties u_properties (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_imem_resp  (i_imem_resp),
    .o_imem_read  (o_imem_read),
    .o_imem_addr  (o_imem_addr),
    .i_dmem_resp  (i_dmem_resp),
    .o_dmem_read  (o_dmem_read),
    .o_dmem_write (o_dmem_write),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata)
);

//--- tests/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_arst_n
);

initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
end

// reset released on a rising edge
initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_arst_n <= 1'b1;
end

endmodule : clock_gen

//--- src/cpu.sv
`timescale 1ns/1ns

module cpu (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_imem_resp,
    input  lc3b_isa_pkg::lc3b_word i_imem_rdata,
    output lc3b_isa_pkg::lc3b_word o_imem_addr,
    output logic                   o_imem_read,
    input  logic                   i_dmem_resp,
    input  lc3b_isa_pkg::lc3b_word i_dmem_rdata,
    output lc3b_isa_pkg::lc3b_word o_dmem_addr,
    output lc3b_isa_pkg::lc3b_word o_dmem_wdata,
    output logic                   o_dmem_read,
    output logic                   o_dmem_write
);

localparam lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000;

lc3b_isa_pkg::lc3b_opcode opcode;
logic ir_5;
lc3b_ctrl_pkg::lc3b_aluop aluop;
lc3b_ctrl_pkg::lc3b_bsel bsel;
lc3b_ctrl_pkg::lc3b_wb_sel wb_sel;
logic load_regfile, load_cc, mem_read, mem_write, is_branch, use_sr2_as_dest;
lc3b_ctrl_pkg::lc3b_fwd_sel fwd_a, fwd_b;
lc3b_isa_pkg::lc3b_reg src1_ex, src2_ex, dest_mem, dest_wb;
logic ld_mem, ld_wb, br_taken, load, flush;

cpu_control u_control (
    .i_opcode          (opcode),
    .i_ir_5            (ir_5),
    .o_aluop           (aluop),
    .o_bsel            (bsel),
    .o_wb_sel          (wb_sel),
    .o_load_regfile    (load_regfile),
    .o_load_cc         (load_cc),
    .o_mem_read        (mem_read),
    .o_mem_write       (mem_write),
    .o_is_branch       (is_branch),
    .o_use_sr2_as_dest (use_sr2_as_dest)
);

cpu_datapath #(
    .RESET_PC (RESET_PC)
) u_datapath (
    .clk,
    .i_arst_n,
    .i_aluop           (aluop),
    .i_bsel            (bsel),
    .i_wb_sel          (wb_sel),
    .i_load_regfile    (load_regfile),
    .i_load_cc         (load_cc),
    .i_mem_read        (mem_read),
    .i_mem_write       (mem_write),
    .i_is_branch       (is_branch),
    .i_use_sr2_as_dest (use_sr2_as_dest),
    .o_opcode          (opcode),
    .o_ir_5            (ir_5),
    .i_load            (load),
    .i_flush           (flush),
    .i_fwd_a           (fwd_a),
    .i_fwd_b           (fwd_b),
    .o_src1_ex         (src1_ex),
    .o_src2_ex         (src2_ex),
    .o_dest_mem        (dest_mem),
    .o_dest_wb         (dest_wb),
    .o_ld_mem          (ld_mem),
    .o_ld_wb           (ld_wb),
    .o_br_taken        (br_taken),
    .i_imem_resp,
    .i_imem_rdata,
    .o_imem_addr,
    .o_imem_read,
    .i_dmem_resp,
    .i_dmem_rdata,
    .o_dmem_addr,
    .o_dmem_wdata,
    .o_dmem_read,
    .o_dmem_write
);

hazard_detection u_hazard (
    .i_imem_read (o_imem_read),
    .i_imem_resp,
    .i_dmem_req  (o_dmem_read | o_dmem_write),
    .i_dmem_resp,
    .i_br_taken  (br_taken),
    .o_load      (load),
    .o_flush     (flush)
);

forwarding_unit u_forwarding (
    .i_src1_ex  (src1_ex),
    .i_src2_ex  (src2_ex),
    .i_dest_mem (dest_mem),
    .i_ld_mem   (ld_mem),
    .i_dest_wb  (dest_wb),
    .i_ld_wb    (ld_wb),
    .o_fwd_a    (fwd_a),
    .o_fwd_b    (fwd_b)
);

endmodule : cpu

//--- src/cpu_datapath.sv
`timescale 1ns/1ns

module cpu_datapath #(
    parameter lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000
) (
    input  logic                       clk,
    input  logic                       i_arst_n,
    // decode fields for the instruction in ID
    input  lc3b_ctrl_pkg::lc3b_aluop   i_aluop,
    input  lc3b_ctrl_pkg::lc3b_bsel    i_bsel,
    input  lc3b_ctrl_pkg::lc3b_wb_sel  i_wb_sel,
    input  logic                       i_load_regfile,
    input  logic                       i_load_cc,
    input  logic                       i_mem_read,
    input  logic                       i_mem_write,
    input  logic                       i_is_branch,
    input  logic                       i_use_sr2_as_dest,
    output lc3b_isa_pkg::lc3b_opcode   o_opcode,
    output logic                       o_ir_5,
    // pipeline control
    input  logic                       i_load,
    input  logic                       i_flush,
    input  lc3b_ctrl_pkg::lc3b_fwd_sel i_fwd_a,
    input  lc3b_ctrl_pkg::lc3b_fwd_sel i_fwd_b,
    output lc3b_isa_pkg::lc3b_reg      o_src1_ex,
    output lc3b_isa_pkg::lc3b_reg      o_src2_ex,
    output lc3b_isa_pkg::lc3b_reg      o_dest_mem,
    output lc3b_isa_pkg::lc3b_reg      o_dest_wb,
    output logic                       o_ld_mem,
    output logic                       o_ld_wb,
    output logic                       o_br_taken,
    // instruction memory
    input  logic                       i_imem_resp,
    input  lc3b_isa_pkg::lc3b_word     i_imem_rdata,
    output lc3b_isa_pkg::lc3b_word     o_imem_addr,
    output logic                       o_imem_read,
    // data memory
    input  logic                       i_dmem_resp,
    input  lc3b_isa_pkg::lc3b_word     i_dmem_rdata,
    output lc3b_isa_pkg::lc3b_word     o_dmem_addr,
    output lc3b_isa_pkg::lc3b_word     o_dmem_wdata,
    output logic                       o_dmem_read,
    output logic                       o_dmem_write
);

lc3b_isa_pkg::lc3b_word pc, pc_id, ir_id, a_id, b_id;
lc3b_isa_pkg::lc3b_reg src1_id, src2_id, dest_ex;
lc3b_ctrl_pkg::lc3b_aluop aluop_ex;
lc3b_ctrl_pkg::lc3b_bsel bsel_ex;
lc3b_ctrl_pkg::lc3b_wb_sel wb_sel_ex, wb_sel_mem;
logic ld_ex, cc_ex, rd_ex, wr_ex, br_ex;
lc3b_isa_pkg::lc3b_word pc_ex, a_ex, b_ex, opa, opb, opb_alu, alu_out, target_ex;
lc3b_isa_pkg::lc3b_offset9 off9_ex;
lc3b_isa_pkg::lc3b_offset6 off6_ex;
lc3b_isa_pkg::lc3b_imm5 imm5_ex;
logic cc_mem, rd_mem, wr_mem, br_mem, dmem_done;
lc3b_isa_pkg::lc3b_word alu_mem, sdata_mem, target_mem, dmem_hold, ld_data, fwd_mem_val;
logic cc_wb, br_wb;
lc3b_isa_pkg::lc3b_word value_wb, target_wb;
lc3b_isa_pkg::lc3b_nzp cc;

function automatic lc3b_isa_pkg::lc3b_word fwd_pick(
    input lc3b_ctrl_pkg::lc3b_fwd_sel sel,
    input lc3b_isa_pkg::lc3b_word     reg_val,
    input lc3b_isa_pkg::lc3b_word     mem_val,
    input lc3b_isa_pkg::lc3b_word     wb_val
);
    case (sel)
        lc3b_ctrl_pkg::fwd_mem: return mem_val;
        lc3b_ctrl_pkg::fwd_wb:  return wb_val;
        default:                return reg_val;
    endcase
endfunction

// fetch
assign o_imem_addr = pc;
assign o_imem_read = 1'b1;

always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        pc    <= RESET_PC;
        ir_id <= '0;
    end else if (i_load) begin
        pc    <= i_flush ? target_wb : pc + 16'd2;
        // all-zero word is BR with nzp 000
        ir_id <= i_flush ? '0 : i_imem_rdata;
    end
end

always_ff @(posedge clk) begin
    if (i_load) begin
        pc_id <= pc + 16'd2;
    end
end

// decode
assign o_opcode = lc3b_isa_pkg::lc3b_opcode'(ir_id[15:12]);
assign o_ir_5   = ir_id[5];
assign src1_id  = ir_id[8:6];
assign src2_id  = i_use_sr2_as_dest ? ir_id[11:9] : ir_id[2:0];

regfile u_regfile (
    .clk,
    .i_arst_n,
    .i_we    (o_ld_wb & i_load),
    .i_dest  (o_dest_wb),
    .i_din   (value_wb),
    .i_src_a (src1_id),
    .i_src_b (src2_id),
    .o_a     (a_id),
    .o_b     (b_id)
);

// pipeline control flags, cleared on reset and on a taken branch
always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        {ld_ex, cc_ex, rd_ex, wr_ex, br_ex} <= '0;
        {o_ld_mem, cc_mem, rd_mem, wr_mem, br_mem} <= '0;
        {o_ld_wb, cc_wb, br_wb} <= '0;
    end else if (i_load) begin
        ld_ex    <= i_load_regfile & ~i_flush;
        cc_ex    <= i_load_cc & ~i_flush;
        rd_ex    <= i_mem_read & ~i_flush;
        wr_ex    <= i_mem_write & ~i_flush;
        br_ex    <= i_is_branch & ~i_flush;
        o_ld_mem <= ld_ex & ~i_flush;
        cc_mem   <= cc_ex & ~i_flush;
        rd_mem   <= rd_ex & ~i_flush;
        wr_mem   <= wr_ex & ~i_flush;
        br_mem   <= br_ex & ~i_flush;
        o_ld_wb  <= o_ld_mem & ~i_flush;
        cc_wb    <= cc_mem & ~i_flush;
        br_wb    <= br_mem & ~i_flush;
    end
end

always_ff @(posedge clk) begin
    if (i_load) begin
        aluop_ex   <= i_aluop;
        bsel_ex    <= i_bsel;
        wb_sel_ex  <= i_wb_sel;
        o_src1_ex  <= src1_id;
        o_src2_ex  <= src2_id;
        dest_ex    <= ir_id[11:9];
        a_ex       <= a_id;
        b_ex       <= b_id;
        off9_ex    <= ir_id[8:0];
        pc_ex      <= pc_id;
        wb_sel_mem <= wb_sel_ex;
        o_dest_mem <= dest_ex;
        alu_mem    <= alu_out;
        sdata_mem  <= opb;
        target_mem <= target_ex;
        value_wb   <= fwd_mem_val;
        o_dest_wb  <= o_dest_mem;
        target_wb  <= target_mem;
    end
end

// execute
assign imm5_ex   = off9_ex[4:0];
assign off6_ex   = off9_ex[5:0];
assign opa       = fwd_pick(i_fwd_a, a_ex, fwd_mem_val, value_wb);
assign opb       = fwd_pick(i_fwd_b, b_ex, fwd_mem_val, value_wb);
assign target_ex = pc_ex + {{6{off9_ex[8]}}, off9_ex, 1'b0};

always_comb begin
    case (bsel_ex)
        lc3b_ctrl_pkg::bsel_imm5: opb_alu = {{11{imm5_ex[4]}}, imm5_ex};
        // word offset scaled to bytes
        lc3b_ctrl_pkg::bsel_off6: opb_alu = {{9{off6_ex[5]}}, off6_ex, 1'b0};
        default:                  opb_alu = opb;
    endcase
end

always_comb begin
    case (aluop_ex)
        lc3b_ctrl_pkg::alu_add: alu_out = opa + opb_alu;
        lc3b_ctrl_pkg::alu_and: alu_out = opa & opb_alu;
        lc3b_ctrl_pkg::alu_not: alu_out = ~opa;
        default:                alu_out = opb_alu;
    endcase
end

// memory, dropped when an older branch in WB is taken
assign o_dmem_addr  = alu_mem;
assign o_dmem_wdata = sdata_mem;
assign o_dmem_read  = rd_mem & ~dmem_done & ~o_br_taken;
assign o_dmem_write = wr_mem & ~dmem_done & ~o_br_taken;

// resp may arrive while the fetch still waits, so keep it until we advance
always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        dmem_done <= 1'b0;
    end else if (i_load) begin
        dmem_done <= 1'b0;
    end else if ((o_dmem_read | o_dmem_write) & i_dmem_resp) begin
        dmem_done <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (o_dmem_read & i_dmem_resp) begin
        dmem_hold <= i_dmem_rdata;
    end
end

assign ld_data     = dmem_done ? dmem_hold : i_dmem_rdata;
assign fwd_mem_val = (wb_sel_mem == lc3b_ctrl_pkg::wb_mem) ? ld_data : alu_mem;

// writeback and branch resolution
always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        cc <= 3'b010;
    end else if (i_load & cc_wb) begin
        cc <= {value_wb[15], value_wb == '0, ~value_wb[15] & (value_wb != '0)};
    end
end

// dest field of a BR holds its nzp bits
assign o_br_taken = br_wb & |(cc & o_dest_wb);

endmodule : cpu_datapath

//--- src/cpu_control.sv
`timescale 1ns/1ns

module cpu_control (
    input  lc3b_isa_pkg::lc3b_opcode  i_opcode,
    input  logic                      i_ir_5,
    output lc3b_ctrl_pkg::lc3b_aluop  o_aluop,
    output lc3b_ctrl_pkg::lc3b_bsel   o_bsel,
    output lc3b_ctrl_pkg::lc3b_wb_sel o_wb_sel,
    output logic                      o_load_regfile,
    output logic                      o_load_cc,
    output logic                      o_mem_read,
    output logic                      o_mem_write,
    output logic                      o_is_branch,
    output logic                      o_use_sr2_as_dest
);

always_comb begin
    // bubble unless the opcode is one we execute
    o_aluop           = lc3b_ctrl_pkg::alu_pass;
    o_bsel            = lc3b_ctrl_pkg::bsel_reg;
    o_wb_sel          = lc3b_ctrl_pkg::wb_alu;
    o_load_regfile    = 1'b0;
    o_load_cc         = 1'b0;
    o_mem_read        = 1'b0;
    o_mem_write       = 1'b0;
    o_is_branch       = 1'b0;
    o_use_sr2_as_dest = 1'b0;
    case (i_opcode)
        lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and: begin
            o_aluop        = (i_opcode == lc3b_isa_pkg::op_add) ? lc3b_ctrl_pkg::alu_add
                                                                : lc3b_ctrl_pkg::alu_and;
            o_bsel         = i_ir_5 ? lc3b_ctrl_pkg::bsel_imm5 : lc3b_ctrl_pkg::bsel_reg;
            o_load_regfile = 1'b1;
            o_load_cc      = 1'b1;
        end
        lc3b_isa_pkg::op_not: begin
            o_aluop        = lc3b_ctrl_pkg::alu_not;
            o_load_regfile = 1'b1;
            o_load_cc      = 1'b1;
        end
        lc3b_isa_pkg::op_ldr: begin
            o_aluop        = lc3b_ctrl_pkg::alu_add;
            o_bsel         = lc3b_ctrl_pkg::bsel_off6;
            o_wb_sel       = lc3b_ctrl_pkg::wb_mem;
            o_load_regfile = 1'b1;
            o_load_cc      = 1'b1;
            o_mem_read     = 1'b1;
        end
        lc3b_isa_pkg::op_str: begin
            // store data register sits in the dest field
            o_aluop           = lc3b_ctrl_pkg::alu_add;
            o_bsel            = lc3b_ctrl_pkg::bsel_off6;
            o_mem_write       = 1'b1;
            o_use_sr2_as_dest = 1'b1;
        end
        lc3b_isa_pkg::op_br: o_is_branch = 1'b1;
        default: ;
    endcase
end

endmodule : cpu_control

//--- src/hazard_detection.sv
`timescale 1ns/1ns

module hazard_detection (
    input  logic i_imem_read,
    input  logic i_imem_resp,
    input  logic i_dmem_req,
    input  logic i_dmem_resp,
    input  logic i_br_taken,
    output logic o_load,
    output logic o_flush
);

logic imem_wait;
logic dmem_wait;

// a request still waiting for its resp pulse
assign imem_wait = i_imem_read & ~i_imem_resp;
assign dmem_wait = i_dmem_req & ~i_dmem_resp;

// whole pipeline advances together or not at all
assign o_load = ~imem_wait & ~dmem_wait;

// taken branch in WB redirects on the next advancing edge
assign o_flush = i_br_taken & o_load;

endmodule : hazard_detection

//--- src/forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit (
    input  lc3b_isa_pkg::lc3b_reg      i_src1_ex,
    input  lc3b_isa_pkg::lc3b_reg      i_src2_ex,
    input  lc3b_isa_pkg::lc3b_reg      i_dest_mem,
    input  logic                       i_ld_mem,
    input  lc3b_isa_pkg::lc3b_reg      i_dest_wb,
    input  logic                       i_ld_wb,
    output lc3b_ctrl_pkg::lc3b_fwd_sel o_fwd_a,
    output lc3b_ctrl_pkg::lc3b_fwd_sel o_fwd_b
);

// the younger producer in MEM wins over WB
always_comb begin
    o_fwd_a = lc3b_ctrl_pkg::fwd_none;
    if (i_ld_mem && i_dest_mem == i_src1_ex) begin
        o_fwd_a = lc3b_ctrl_pkg::fwd_mem;
    end else if (i_ld_wb && i_dest_wb == i_src1_ex) begin
        o_fwd_a = lc3b_ctrl_pkg::fwd_wb;
    end
end

always_comb begin
    o_fwd_b = lc3b_ctrl_pkg::fwd_none;
    if (i_ld_mem && i_dest_mem == i_src2_ex) begin
        o_fwd_b = lc3b_ctrl_pkg::fwd_mem;
    end else if (i_ld_wb && i_dest_wb == i_src2_ex) begin
        o_fwd_b = lc3b_ctrl_pkg::fwd_wb;
    end
end

endmodule : forwarding_unit

//--- src/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_we,
    input  lc3b_isa_pkg::lc3b_reg  i_dest,
    input  lc3b_isa_pkg::lc3b_word i_din,
    input  lc3b_isa_pkg::lc3b_reg  i_src_a,
    input  lc3b_isa_pkg::lc3b_reg  i_src_b,
    output lc3b_isa_pkg::lc3b_word o_a,
    output lc3b_isa_pkg::lc3b_word o_b
);

lc3b_isa_pkg::lc3b_word regs [8];

always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
        end
    end else if (i_we) begin
        regs[i_dest] <= i_din;
    end
end

// write-through so decode sees the value written back this cycle
assign o_a = (i_we && i_dest == i_src_a) ? i_din : regs[i_src_a];
assign o_b = (i_we && i_dest == i_src_b) ? i_din : regs[i_src_b];

endmodule : regfile

//--- src/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

// alu function in EX
typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_pass
} lc3b_aluop;

// where an EX operand comes from
typedef enum logic [1:0] {
    fwd_none,
    fwd_mem,
    fwd_wb
} lc3b_fwd_sel;

// alu b operand
typedef enum logic [1:0] {
    bsel_reg,
    bsel_imm5,
    bsel_off6
} lc3b_bsel;

// value written back
typedef enum logic {
    wb_alu,
    wb_mem
} lc3b_wb_sel;

endpackage : lc3b_ctrl_pkg

//--- src/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

// one machine word, data or byte address
typedef logic [15:0] lc3b_word;

// register index and condition codes
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

// instruction fields
typedef logic [4:0] lc3b_imm5;
typedef logic [5:0] lc3b_offset6;
typedef logic [8:0] lc3b_offset9;

// encoding of ir[15:12]
typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ldb  = 4'b0010,
    op_stb  = 4'b0011,
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_shf  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
} lc3b_opcode;

endpackage : lc3b_isa_pkg
